// ==== vlog.f ====
source/debug_pkg.sv
source/cmd_decoder.sv
source/run_control.sv
source/dump_serializer.sv
source/debug_unit.sv
testbench/debug_unit_asserts.sv
testbench/tb_debug_unit.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_debug_unit
RTL_TOP   = debug_unit
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+100

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

.PHONY: all build run lint clean

// ==== testbench/tb_debug_unit.sv ====
module tb_debug_unit;
    import debug_pkg::*;

    localparam int          NUM_REGISTERS = 32;
    localparam int          MEM_ADDR_W    = 6;
    localparam logic [31:0] SEED          = 32'h8c21_82e8;
    localparam int          MAX_WORDS     = 12;
    localparam int          NUM_READS     = 4;
    localparam int          MAX_STEPS     = 8;
    localparam int          MAX_GAP       = 12;   // Worst cycles per byte on either side
    // Dumps, reads, load, steps and two runs of the PC up to a byte-sized stop PC
    localparam int WORST_BYTES = 2 * (NUM_REGISTERS * 4 + 6) + NUM_READS * 7
                               + 4 * MAX_WORDS + 8 + MAX_STEPS + 2 * 260;
    localparam int CYCLE_LIMIT = 2 * WORST_BYTES * MAX_GAP;

    logic                            clk = 1'b0;
    logic                            reset;
    logic                            rx_valid;
    logic [BYTE_W-1:0]               rx_data;
    logic                            tx_done = 1'b0;
    logic [WORD_W*NUM_REGISTERS-1:0] registers;
    logic [IF_ID_W-1:0]              if_id;
    logic [WORD_W-1:0]               dmem_data = '0;
    logic [WORD_W-1:0]               pc = '0;
    logic                            o_tx_start;
    logic [BYTE_W-1:0]               o_tx_data;
    logic                            o_imem_we;
    logic [WORD_W-1:0]               o_imem_addr;
    logic [WORD_W-1:0]               o_imem_data;
    logic [MEM_ADDR_W-1:0]           o_dmem_addr;
    logic                            o_cpu_enable;

    logic [31:0]       rng = SEED;
    logic [31:0]       sink_rng = ~SEED;          // Separate stream for the sink delays
    logic              sink_busy = 1'b0;
    logic [2:0]        sink_wait = '0;
    logic              rx_valid_q = 1'b0;
    logic              load_window = 1'b0;        // CPU must be held off while set
    int                cycles = 0;
    int                assert_errors;
    logic [BYTE_W-1:0] rx_queue [$];
    logic [WORD_W-1:0] imem_addr_q [$];
    logic [WORD_W-1:0] imem_data_q [$];

    debug_unit #(
        .NUM_REGISTERS(NUM_REGISTERS),
        .MEM_ADDR_W   (MEM_ADDR_W)
    ) uut (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_rx_valid   (rx_valid),
        .i_rx_data    (rx_data),
        .i_tx_done    (tx_done),
        .i_registers  (registers),
        .i_if_id      (if_id),
        .i_dmem_data  (dmem_data),
        .i_pc         (pc),
        .o_tx_start   (o_tx_start),
        .o_tx_data    (o_tx_data),
        .o_imem_we    (o_imem_we),
        .o_imem_addr  (o_imem_addr),
        .o_imem_data  (o_imem_data),
        .o_dmem_addr  (o_dmem_addr),
        .o_cpu_enable (o_cpu_enable)
    );

    assign assert_errors = uut.u_dump_serializer.u_tx_asserts.fail_count
                         + uut.u_run_control.u_step_asserts.fail_count;

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_next();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Data memory contents mix every address bit
    function automatic logic [31:0] mem_hash(input logic [MEM_ADDR_W-1:0] a);
        logic [31:0] x;
        x = 32'(a) * 32'h9e37_79b1;
        return x ^ (x >> 15) ^ 32'h5a5a_0f0f;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic send_byte(input logic [BYTE_W-1:0] b);
        int gap;
        gap = 2 + int'(rand_next() % 32'd4);     // 2 to 5 idle cycles
        rx_valid <= 1'b1;
        rx_data  <= b;
        @(posedge clk);
        rx_valid <= 1'b0;
        repeat (gap) @(posedge clk);
    endtask

    task automatic wait_for_reply(input int n);
        while (rx_queue.size() < n) @(posedge clk);
        @(posedge clk);                           // Let the last i_tx_done reach the DUT
    endtask

    task automatic expect_byte(input logic [BYTE_W-1:0] expected);
        logic [BYTE_W-1:0] got;
        got = rx_queue.pop_front();
        compare_value("o_tx_data", 32'(expected), 32'(got));
    endtask

    // Sink with random back-pressure
    always @(posedge clk) begin
        if (reset) begin
            tx_done   <= 1'b0;
            sink_busy <= 1'b0;
            sink_wait <= '0;
        end else begin
            tx_done <= 1'b0;
            if (o_tx_start) begin
                sink_rng = xorshift(sink_rng);
                sink_wait <= sink_rng[2:0];
                sink_busy <= 1'b1;
            end else if (sink_busy) begin
                if (sink_wait == 3'd0) begin
                    tx_done   <= 1'b1;
                    sink_busy <= 1'b0;
                    rx_queue.push_back(o_tx_data);
                end else begin
                    sink_wait <= sink_wait - 3'd1;
                end
            end
        end
    end

    always @(posedge clk) dmem_data <= mem_hash(o_dmem_addr);   // One cycle late

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (o_cpu_enable) begin
            pc <= pc + 32'd1;
        end
    end

    // Instruction memory writes and the enable during a load
    always @(posedge clk) begin
        rx_valid_q <= rx_valid;
        if (o_imem_we) begin
            compare_value("i_rx_valid one cycle before o_imem_we", 32'd1, 32'(rx_valid_q));
            imem_addr_q.push_back(o_imem_addr);
            imem_data_q.push_back(o_imem_data);
        end
        if (load_window) begin
            compare_value("o_cpu_enable", 32'd0, 32'(o_cpu_enable));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (assert_errors != 0) begin
            $display("An assertion on the transmit handshake or the step enable failed");
            $display("TESTBENCH FAILED");
            $fatal(1, "assertion failure");
        end else if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic stop_at_pc();
        logic [31:0] r;
        logic [7:0]  p;
        logic [31:0] pc_read;
        logic [31:0] expected;
        for (int round = 0; round < 2; round++) begin
            r = rand_next();
            p = (round == 0) ? {1'b1, r[6:0]} : r[7:0];   // First stop lies ahead of the PC
            send_byte(CMD_STOP_PC);
            send_byte(p);
            wait_for_reply(1);
            expect_byte(ACK_BYTE);
            send_byte(CMD_ARM);
            pc_read  = pc;
            expected = (32'(p) > pc_read) ? 32'(p) : pc_read;
            while (o_cpu_enable) @(posedge clk);
            repeat (4) @(posedge clk);
            compare_value("i_pc", expected, pc);
        end
    endtask

    task automatic dump_snapshots();
        for (int rep = 0; rep < 2; rep++) begin
            for (int i = 0; i < NUM_REGISTERS; i++) begin
                registers[i*WORD_W +: WORD_W] <= rand_next();
            end
            if_id <= rand_next();
            @(posedge clk);
            send_byte(CMD_DUMP_REGS);
            wait_for_reply(NUM_REGISTERS * 4 + 1);
            for (int b = 0; b < NUM_REGISTERS * 4; b++) begin
                expect_byte(registers[b*8 +: 8]);
            end
            expect_byte(ACK_BYTE);
            send_byte(CMD_DUMP_IF_ID);
            wait_for_reply(5);
            for (int b = 0; b < 4; b++) begin
                expect_byte(if_id[b*8 +: 8]);
            end
            expect_byte(ACK_BYTE);
        end
    endtask

    task automatic read_data_memory();
        logic [7:0]  addr;
        logic [31:0] word;
        for (int rep = 0; rep < NUM_READS; rep++) begin
            addr = 8'(rand_next() >> 24);
            word = mem_hash(addr[MEM_ADDR_W-1:0]);
            send_byte(CMD_READ_MEM);
            send_byte(addr);
            wait_for_reply(5);
            for (int b = 0; b < 4; b++) begin
                expect_byte(word[b*8 +: 8]);
            end
            expect_byte(ACK_BYTE);
            compare_value("o_dmem_addr", 32'(addr[MEM_ADDR_W-1:0]), 32'(o_dmem_addr));
        end
    endtask

    task automatic load_program();
        int          n;
        logic [31:0] words [MAX_WORDS];
        n = 1 + int'(rand_next() % 32'(MAX_WORDS));
        for (int w = 0; w < n; w++) begin
            words[w] = rand_next();
        end
        imem_addr_q.delete();
        imem_data_q.delete();
        send_byte(CMD_LOAD);
        load_window <= 1'b1;
        send_byte(8'(n));
        for (int w = 0; w < n; w++) begin
            for (int b = 0; b < 4; b++) begin
                if (w == n - 1 && b == 3) begin
                    load_window <= 1'b0;          // Load ends with this byte
                end
                send_byte(words[w][b*8 +: 8]);
            end
        end
        compare_value("imem write count", 32'(n), 32'(imem_addr_q.size()));
        for (int w = 0; w < n; w++) begin
            compare_value("o_imem_addr", 32'(w), imem_addr_q[w]);
            compare_value("o_imem_data", words[w], imem_data_q[w]);
        end
        send_byte(CMD_DUMP_REGS);                 // Only execute is taken now
        repeat (20) @(posedge clk);
        compare_value("bytes sent before execute", 32'd0, 32'(rx_queue.size()));
        send_byte(CMD_EXECUTE);
        wait_for_reply(1);
        expect_byte(ACK_BYTE);
    endtask

    task automatic single_step();
        int          k;
        logic [31:0] pc_start;
        send_byte(CMD_STEP_MODE);
        pc_start = pc;
        k = 1 + int'(rand_next() % 32'(MAX_STEPS));
        for (int s = 0; s < k; s++) begin
            rx_valid <= 1'b1;
            rx_data  <= CMD_STEP;
            @(posedge clk);
            rx_valid <= 1'b0;
            @(posedge clk);
            compare_value("o_cpu_enable", 32'd0, 32'(o_cpu_enable));
            @(posedge clk);
            compare_value("o_cpu_enable", 32'd1, 32'(o_cpu_enable));   // Two cycles after valid
            @(posedge clk);
            compare_value("o_cpu_enable", 32'd0, 32'(o_cpu_enable));
            repeat (int'(rand_next() % 32'd3)) @(posedge clk);
        end
        repeat (4) @(posedge clk);
        compare_value("i_pc", pc_start + 32'(k), pc);
        send_byte(CMD_CONTINUOUS);
        compare_value("o_cpu_enable", 32'd1, 32'(o_cpu_enable));
    endtask

    task automatic ignore_unknown_byte();
        send_byte(8'h20 + 8'(rand_next() % 32'd192));   // Above every command code
        repeat (30) @(posedge clk);
        compare_value("bytes sent for unknown command", 32'd0, 32'(rx_queue.size()));
    endtask

    initial begin
        reset     <= 1'b1;
        rx_valid  <= 1'b0;
        rx_data   <= '0;
        registers <= '0;
        if_id     <= '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        compare_value("o_tx_start", 32'd0, 32'(o_tx_start));
        compare_value("o_imem_we", 32'd0, 32'(o_imem_we));
        compare_value("o_cpu_enable", 32'd1, 32'(o_cpu_enable));
        stop_at_pc();
        dump_snapshots();
        read_data_memory();
        load_program();
        single_step();
        ignore_unknown_byte();
        repeat (4) @(posedge clk);
        if (assert_errors != 0) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== testbench/debug_unit_asserts.sv ====
module debug_unit_asserts (
    input logic i_clk,
    input logic i_reset,
    input logic i_tx_start,
    input logic i_tx_done,
    input logic i_step_en
);
    int   fail_count = 0;                         // Read by the testbench top
    logic tx_busy;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            tx_busy <= 1'b0;
        end else if (i_tx_start) begin
            tx_busy <= 1'b1;
        end else if (i_tx_done) begin
            tx_busy <= 1'b0;
        end
    end

    tx_start_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_tx_start |=> !i_tx_start)
    else begin
        fail_count++;
        $error("o_tx_start held for more than one cycle");
    end

    tx_start_after_done: assert property (@(posedge i_clk) disable iff (i_reset)
        i_tx_start |-> !tx_busy)
    else begin
        fail_count++;
        $error("o_tx_start raised before i_tx_done of the previous byte");
    end

    step_enable_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_step_en |=> !i_step_en)
    else begin
        fail_count++;
        $error("step enable held for more than one cycle");
    end

endmodule

bind dump_serializer debug_unit_asserts u_tx_asserts (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_tx_start (o_tx_start),
    .i_tx_done  (i_tx_done),
    .i_step_en  (1'b0)
);

bind run_control debug_unit_asserts u_step_asserts (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_tx_start (1'b0),
    .i_tx_done  (1'b0),
    .i_step_en  (step_en)
);

// ==== source/debug_unit.sv ====
module debug_unit #(
    parameter int NUM_REGISTERS = 32,
    parameter int MEM_ADDR_W    = 6
) (
    input  logic                                       i_clk,
    input  logic                                       i_reset,
    input  logic                                       i_rx_valid,
    input  logic [debug_pkg::BYTE_W-1:0]               i_rx_data,
    input  logic                                       i_tx_done,
    input  logic [debug_pkg::WORD_W*NUM_REGISTERS-1:0] i_registers,
    input  logic [debug_pkg::IF_ID_W-1:0]              i_if_id,
    input  logic [debug_pkg::WORD_W-1:0]               i_dmem_data,
    input  logic [debug_pkg::WORD_W-1:0]               i_pc,
    output logic                                       o_tx_start,
    output logic [debug_pkg::BYTE_W-1:0]               o_tx_data,
    output logic                                       o_imem_we,
    output logic [debug_pkg::WORD_W-1:0]               o_imem_addr,
    output logic [debug_pkg::WORD_W-1:0]               o_imem_data,
    output logic [MEM_ADDR_W-1:0]                      o_dmem_addr,
    output logic                                       o_cpu_enable
);
    import debug_pkg::*;

    logic              dump_req;
    dump_src_t         dump_src;
    logic              mode_set;
    logic              mode_step_sel;
    logic              step;
    logic              arm;
    logic              stop_pc_we;
    logic [WORD_W-1:0] stop_pc_value;
    logic              load_active;

    cmd_decoder #(
        .MEM_ADDR_W(MEM_ADDR_W)
    ) u_cmd_decoder (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_rx_valid      (i_rx_valid),
        .i_rx_data       (i_rx_data),
        .o_dump_req      (dump_req),
        .o_dump_src      (dump_src),
        .o_mode_set      (mode_set),
        .o_mode_step_sel (mode_step_sel),
        .o_step          (step),
        .o_arm           (arm),
        .o_stop_pc_we    (stop_pc_we),
        .o_stop_pc_value (stop_pc_value),
        .o_load_active   (load_active),
        .o_imem_we       (o_imem_we),
        .o_imem_addr     (o_imem_addr),
        .o_imem_data     (o_imem_data),
        .o_dmem_addr     (o_dmem_addr)
    );

    run_control u_run_control (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_mode_set      (mode_set),
        .i_mode_step_sel (mode_step_sel),
        .i_step          (step),
        .i_arm           (arm),
        .i_stop_pc_we    (stop_pc_we),
        .i_stop_pc_value (stop_pc_value),
        .i_load_active   (load_active),
        .i_pc            (i_pc),
        .o_cpu_enable    (o_cpu_enable)
    );

    dump_serializer #(
        .NUM_REGISTERS(NUM_REGISTERS)
    ) u_dump_serializer (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_dump_req  (dump_req),
        .i_dump_src  (dump_src),
        .i_registers (i_registers),
        .i_if_id     (i_if_id),
        .i_dmem_data (i_dmem_data),
        .i_tx_done   (i_tx_done),
        .o_tx_start  (o_tx_start),
        .o_tx_data   (o_tx_data)
    );

endmodule

// ==== source/dump_serializer.sv ====
module dump_serializer #(
    parameter int NUM_REGISTERS = 32
) (
    input  logic                                       i_clk,
    input  logic                                       i_reset,
    input  logic                                       i_dump_req,
    input  debug_pkg::dump_src_t                       i_dump_src,
    input  logic [debug_pkg::WORD_W*NUM_REGISTERS-1:0] i_registers,
    input  logic [debug_pkg::IF_ID_W-1:0]              i_if_id,
    input  logic [debug_pkg::WORD_W-1:0]               i_dmem_data,
    input  logic                                       i_tx_done,
    output logic                                       o_tx_start,
    output logic [debug_pkg::BYTE_W-1:0]               o_tx_data
);
    import debug_pkg::*;

    localparam int REG_BYTES   = (WORD_W * NUM_REGISTERS + BYTE_W - 1) / BYTE_W;
    localparam int IF_ID_BYTES = (IF_ID_W + BYTE_W - 1) / BYTE_W;
    localparam int MEM_BYTES   = (WORD_W + BYTE_W - 1) / BYTE_W;
    localparam int SNAP_BYTES  = (REG_BYTES > IF_ID_BYTES) ? REG_BYTES : IF_ID_BYTES;
    localparam int SNAP_W      = SNAP_BYTES * BYTE_W;
    localparam int CNT_W       = $clog2(SNAP_BYTES + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_CAPTURE,
        S_SEND,
        S_WAIT
    } state_t;

    state_t           state;
    dump_src_t        src;
    logic [CNT_W-1:0] bytes_left;                 // Data bytes still to go before the ack
    logic             last_byte;
    logic [SNAP_W-1:0] snap;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state      <= S_IDLE;
            src        <= DUMP_ACK;
            bytes_left <= '0;
            last_byte  <= 1'b0;
            o_tx_start <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_dump_req) begin
                        src   <= i_dump_src;
                        state <= S_CAPTURE;
                    end
                end
                // One cycle later so the data memory has answered the new address
                S_CAPTURE: begin
                    case (src)
                        DUMP_REGS:  bytes_left <= CNT_W'(REG_BYTES);
                        DUMP_IF_ID: bytes_left <= CNT_W'(IF_ID_BYTES);
                        DUMP_MEM:   bytes_left <= CNT_W'(MEM_BYTES);
                        default:    bytes_left <= '0;
                    endcase
                    state <= S_SEND;
                end
                S_SEND: begin
                    o_tx_start <= 1'b1;
                    last_byte  <= (bytes_left == '0);
                    if (bytes_left != '0) begin
                        bytes_left <= bytes_left - CNT_W'(1);
                    end
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    if (i_tx_done) begin
                        state <= last_byte ? S_IDLE : S_SEND;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == S_CAPTURE) begin
            case (src)
                DUMP_REGS:  snap <= SNAP_W'(i_registers);
                DUMP_IF_ID: snap <= SNAP_W'(i_if_id);
                default:    snap <= SNAP_W'(i_dmem_data);
            endcase
        end else if (state == S_SEND) begin
            snap      <= snap >> BYTE_W;          // Least significant byte goes out first
            o_tx_data <= (bytes_left == '0) ? ACK_BYTE : snap[BYTE_W-1:0];
        end
    end

endmodule

// ==== source/run_control.sv ====
module run_control (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         i_mode_set,
    input  logic                         i_mode_step_sel,
    input  logic                         i_step,
    input  logic                         i_arm,
    input  logic                         i_stop_pc_we,
    input  logic [debug_pkg::WORD_W-1:0] i_stop_pc_value,
    input  logic                         i_load_active,
    input  logic [debug_pkg::WORD_W-1:0] i_pc,
    output logic                         o_cpu_enable
);
    import debug_pkg::*;

    logic              step_mode;                 // 0 continuous, 1 single step
    logic              armed;
    logic              load_q;
    logic              step_en;
    logic              at_stop;
    logic [WORD_W-1:0] stop_pc;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            step_mode <= 1'b0;
        end else if (i_mode_set) begin
            step_mode <= i_mode_step_sel;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            stop_pc <= '0;
        end else if (i_stop_pc_we) begin
            stop_pc <= i_stop_pc_value;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            load_q <= 1'b0;
            armed  <= 1'b0;
        end else begin
            load_q <= i_load_active;
            if (i_load_active && !load_q) begin
                armed <= 1'b0;                    // A new program disarms the stop PC
            end else if (i_arm) begin
                armed <= 1'b1;
            end
        end
    end

    // One enable cycle per step command in step mode
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            step_en <= 1'b0;
        end else begin
            step_en <= i_step && step_mode;
        end
    end

    assign at_stop      = armed && (i_pc >= stop_pc);
    assign o_cpu_enable = !i_load_active && (step_mode ? step_en : !at_stop);

endmodule

// ==== source/cmd_decoder.sv ====
module cmd_decoder #(
    parameter int MEM_ADDR_W = 6
) (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         i_rx_valid,
    input  logic [debug_pkg::BYTE_W-1:0] i_rx_data,
    output logic                         o_dump_req,
    output debug_pkg::dump_src_t         o_dump_src,
    output logic                         o_mode_set,
    output logic                         o_mode_step_sel,
    output logic                         o_step,
    output logic                         o_arm,
    output logic                         o_stop_pc_we,
    output logic [debug_pkg::WORD_W-1:0] o_stop_pc_value,
    output logic                         o_load_active,
    output logic                         o_imem_we,
    output logic [debug_pkg::WORD_W-1:0] o_imem_addr,
    output logic [debug_pkg::WORD_W-1:0] o_imem_data,
    output logic [MEM_ADDR_W-1:0]        o_dmem_addr
);
    import debug_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_STOP_PC,
        S_COUNT,
        S_WORDS,
        S_EXEC
    } state_t;

    state_t            state;
    logic [BYTE_W-1:0] n_words;                   // Program length N
    logic [BYTE_W-1:0] word_idx;
    logic [1:0]        byte_cnt;                  // Byte position inside the word
    logic [WORD_W-1:0] word_buf;
    logic [WORD_W-1:0] word_next;

    assign word_next = {i_rx_data, word_buf[WORD_W-1:BYTE_W]};  // LSB arrives first

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state           <= S_IDLE;
            o_dump_req      <= 1'b0;
            o_dump_src      <= DUMP_ACK;
            o_mode_set      <= 1'b0;
            o_mode_step_sel <= 1'b0;
            o_step          <= 1'b0;
            o_arm           <= 1'b0;
            o_stop_pc_we    <= 1'b0;
            o_load_active   <= 1'b0;
            o_imem_we       <= 1'b0;
            o_dmem_addr     <= '0;
            n_words         <= '0;
            word_idx        <= '0;
            byte_cnt        <= '0;
        end else begin
            o_dump_req   <= 1'b0;
            o_mode_set   <= 1'b0;
            o_step       <= 1'b0;
            o_arm        <= 1'b0;
            o_stop_pc_we <= 1'b0;
            o_imem_we    <= 1'b0;
            if (i_rx_valid) begin
                case (state)
                    S_IDLE: begin
                        case (i_rx_data)
                            CMD_DUMP_REGS: begin
                                o_dump_req <= 1'b1;
                                o_dump_src <= DUMP_REGS;
                            end
                            CMD_DUMP_IF_ID: begin
                                o_dump_req <= 1'b1;
                                o_dump_src <= DUMP_IF_ID;
                            end
                            CMD_READ_MEM: state <= S_ADDR;
                            CMD_STOP_PC:  state <= S_STOP_PC;
                            CMD_LOAD: begin
                                o_load_active <= 1'b1;   // Holds the CPU off until the last word
                                state         <= S_COUNT;
                            end
                            CMD_CONTINUOUS: begin
                                o_mode_set      <= 1'b1;
                                o_mode_step_sel <= 1'b0;
                            end
                            CMD_STEP_MODE: begin
                                o_mode_set      <= 1'b1;
                                o_mode_step_sel <= 1'b1;
                            end
                            CMD_STEP: o_step <= 1'b1;
                            CMD_ARM:  o_arm  <= 1'b1;
                            default:  state  <= S_IDLE;  // Unknown byte
                        endcase
                    end
                    S_ADDR: begin
                        o_dmem_addr <= MEM_ADDR_W'(i_rx_data);
                        o_dump_req  <= 1'b1;
                        o_dump_src  <= DUMP_MEM;
                        state       <= S_IDLE;
                    end
                    S_STOP_PC: begin
                        o_stop_pc_we <= 1'b1;
                        o_dump_req   <= 1'b1;
                        o_dump_src   <= DUMP_ACK;
                        state        <= S_IDLE;
                    end
                    S_COUNT: begin
                        o_stop_pc_we <= 1'b1;
                        n_words      <= i_rx_data;
                        word_idx     <= '0;
                        byte_cnt     <= '0;
                        if (i_rx_data == '0) begin
                            o_load_active <= 1'b0;
                            state         <= S_EXEC;
                        end else begin
                            state <= S_WORDS;
                        end
                    end
                    S_WORDS: begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) begin
                            o_imem_we <= 1'b1;
                            word_idx  <= word_idx + 8'd1;
                            if (word_idx == n_words - 8'd1) begin
                                o_load_active <= 1'b0;
                                state         <= S_EXEC;
                            end
                        end
                    end
                    S_EXEC: begin
                        if (i_rx_data == CMD_EXECUTE) begin
                            o_dump_req <= 1'b1;
                            o_dump_src <= DUMP_ACK;
                            state      <= S_IDLE;
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rx_valid) begin
            if (state == S_COUNT) begin
                o_stop_pc_value <= WORD_W'(i_rx_data) + WORD_W'(STOP_PC_MARGIN);
            end else if (state == S_STOP_PC) begin
                o_stop_pc_value <= WORD_W'(i_rx_data);
            end
            if (state == S_WORDS) begin
                word_buf <= word_next;
                if (byte_cnt == 2'd3) begin
                    o_imem_data <= word_next;
                    o_imem_addr <= WORD_W'(word_idx);
                end
            end
        end
    end

endmodule

// ==== source/debug_pkg.sv ====
package debug_pkg;

    localparam int WORD_W  = 32;                  // Data, instruction and PC width
    localparam int BYTE_W  = 8;
    localparam int IF_ID_W = 32;

    // Host command bytes
    localparam logic [BYTE_W-1:0] CMD_DUMP_REGS  = 8'h01;
    localparam logic [BYTE_W-1:0] CMD_DUMP_IF_ID = 8'h02;
    localparam logic [BYTE_W-1:0] CMD_LOAD       = 8'h07;
    localparam logic [BYTE_W-1:0] CMD_CONTINUOUS = 8'h08;
    localparam logic [BYTE_W-1:0] CMD_STEP_MODE  = 8'h09;
    localparam logic [BYTE_W-1:0] CMD_STEP       = 8'h0A;
    localparam logic [BYTE_W-1:0] CMD_READ_MEM   = 8'h0B;
    localparam logic [BYTE_W-1:0] CMD_ARM        = 8'h0D;
    localparam logic [BYTE_W-1:0] CMD_STOP_PC    = 8'h0E;
    localparam logic [BYTE_W-1:0] CMD_EXECUTE    = 8'h11;

    localparam logic [BYTE_W-1:0] ACK_BYTE = 8'h52;   // ASCII "R"

    localparam int STOP_PC_MARGIN = 5;            // Default stop PC is N plus this

    typedef enum logic [1:0] {
        DUMP_REGS  = 2'd0,
        DUMP_IF_ID = 2'd1,
        DUMP_MEM   = 2'd2,
        DUMP_ACK   = 2'd3                         // Acknowledge only with no data bytes
    } dump_src_t;

endpackage
